// ==== design/acq_cfg_pkg.sv ====
package acq_cfg_pkg;

    // circular sample buffer geometry
    localparam int BUF_DEPTH = 64;
    localparam int BUF_AW = 6;

    // one buffer word is a packed pair of 12-bit samples in 16-bit halves
    localparam int BUF_WORD_W = 32;

    // a data burst is four buffer words, giving one 128-bit record word
    localparam int BURST_WORDS = 4;
    localparam int REC_W = BUF_WORD_W * BURST_WORDS;

    // record words allowed in flight toward the memory writer
    localparam int CREDIT_MAX = 4;

    // flop depth on the enable and trigger inputs
    localparam int SYNC_STAGES = 4;

    // buffer address, wraps modulo BUF_DEPTH
    typedef logic [BUF_AW-1:0] buf_addr_t;

    // raw adc word as written into the buffer
    typedef logic [BUF_WORD_W-1:0] buf_word_t;

    // one record word toward the memory writer
    typedef logic [REC_W-1:0] rec_word_t;

    typedef logic [7:0] burst_cnt_t;

    // holds 0 up to CREDIT_MAX
    typedef logic [2:0] credit_cnt_t;

    typedef logic [15:0] fill_num_t;

    typedef logic [31:0] csum_t;

endpackage

// ==== design/acq_rec_pkg.sv ====
package acq_rec_pkg;

    // record tags sit in bits 127:124
    typedef logic [3:0] tag_t;

    localparam tag_t TAG_FILL_HDR = 4'hF;
    localparam tag_t TAG_WFM_HDR = 4'hA;
    localparam tag_t TAG_CSUM = 4'hC;

    // {acq_enable1, acq_enable0}, zero means acquisition is off
    typedef logic [1:0] fill_type_t;

    // bursts per fill, indexed by fill type
    localparam acq_cfg_pkg::burst_cnt_t FILL_BURSTS [4] = '{8'd0, 8'd2, 8'd4, 8'd8};

    // state indices into the one-hot sequencer vector
    typedef enum logic [3:0] {
        IDLE,
        WATCH_FOR_TRIG,
        FILL_INIT1,
        FILL_INIT2,
        WAVEFORM_INIT1,
        WAVEFORM_INIT2,
        WAVEFORM_INIT3,
        RUN1,
        RUN2,
        RUN3,
        RUN4,
        CHECKSUM1,
        CHECKSUM2,
        DRAIN_WAIT,
        DONE
    } seq_state_t;

    localparam int NUM_STATES = 15;

    typedef logic [NUM_STATES-1:0] state_vec_t;

endpackage

// ==== design/acq_ctl_if.sv ====
interface acq_ctl_if;
    import acq_cfg_pkg::*;
    import acq_rec_pkg::*;

    // strobes from the sequencer, all registered
    fill_type_t fill_type;
    logic fill_hdr_sel;
    logic wfm_hdr_sel;
    logic dat_sel;
    logic csum_sel;
    logic csum_update;
    logic out_valid;
    logic burst_cntr_init;
    logic burst_cntr_en;
    logic fill_cntr_en;
    logic init_rd_addr;
    logic fetch_burst;
    logic capture_en;

    // status back to the sequencer
    logic burst_cntr_zero;
    logic credit_ok;
    logic credits_home;

    // datapath values shared by the reader and the builder
    burst_cnt_t burst_total;
    buf_addr_t start_addr;
    rec_word_t burst_data;

    modport seq (
        output fill_type, fill_hdr_sel, wfm_hdr_sel, dat_sel, csum_sel, csum_update,
        output out_valid, burst_cntr_init, burst_cntr_en, fill_cntr_en,
        output init_rd_addr, fetch_burst, capture_en,
        input  burst_cntr_zero, credit_ok, credits_home
    );

    modport reader (
        input  init_rd_addr, fetch_burst, capture_en, burst_total,
        output burst_data, start_addr
    );

    modport builder (
        input  fill_type, fill_hdr_sel, wfm_hdr_sel, dat_sel, csum_sel, csum_update,
        input  out_valid, burst_cntr_init, burst_cntr_en, fill_cntr_en,
        input  burst_data, start_addr,
        output burst_cntr_zero, credit_ok, credits_home, burst_total
    );

endinterface

// ==== design/adc_acq_sm_cbuf.sv ====
module adc_acq_sm_cbuf (
    input  logic   clk,
    input  logic   adc_acq_full_reset,
    input  logic   acq_enable0,
    input  logic   acq_enable1,
    input  logic   acq_trig,
    acq_ctl_if.seq ctl,
    output logic   acq_done,
    output logic   sm_idle
);
    import acq_cfg_pkg::*;
    import acq_rec_pkg::*;

    // shift registers, bit 0 takes the raw input
    logic [SYNC_STAGES-1:0] en0_sync;
    logic [SYNC_STAGES-1:0] en1_sync;
    logic [SYNC_STAGES-1:0] trig_sync;

    fill_type_t fill_type_sync;
    logic mode_enabled;
    logic trig_seen;

    state_vec_t cs;
    state_vec_t ns;

    // enables and trigger come from another clock domain
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            en0_sync <= '0;
            en1_sync <= '0;
            trig_sync <= '0;
        end else begin
            en0_sync <= {en0_sync[SYNC_STAGES-2:0], acq_enable0};
            en1_sync <= {en1_sync[SYNC_STAGES-2:0], acq_enable1};
            trig_sync <= {trig_sync[SYNC_STAGES-2:0], acq_trig};
        end
    end

    assign fill_type_sync = {en1_sync[SYNC_STAGES-1], en0_sync[SYNC_STAGES-1]};
    // any nonzero fill type arms the sequencer
    assign mode_enabled = |fill_type_sync;
    assign trig_seen = trig_sync[SYNC_STAGES-1];

    // state register, comes out of reset in IDLE
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            cs <= '0;
            cs[IDLE] <= 1'b1;
        end else begin
            cs <= ns;
        end
    end

    // next state, exactly one bit of ns is set
    always_comb begin
        ns = '0;
        case (1'b1)
            // wait until armed
            cs[IDLE]: ns[mode_enabled ? WATCH_FOR_TRIG : IDLE] = 1'b1;
            // no trigger yet, so go back and recheck the enables
            cs[WATCH_FOR_TRIG]: ns[trig_seen ? FILL_INIT1 : IDLE] = 1'b1;
            // select states wait for a free credit before their write state
            cs[FILL_INIT1]: ns[ctl.credit_ok ? FILL_INIT2 : FILL_INIT1] = 1'b1;
            cs[FILL_INIT2]: ns[WAVEFORM_INIT1] = 1'b1;
            cs[WAVEFORM_INIT1]: ns[WAVEFORM_INIT2] = 1'b1;
            cs[WAVEFORM_INIT2]: ns[ctl.credit_ok ? WAVEFORM_INIT3 : WAVEFORM_INIT2] = 1'b1;
            cs[WAVEFORM_INIT3]: ns[RUN1] = 1'b1;
            // burst fetch in RUN1, data ready by RUN3
            cs[RUN1]: ns[RUN2] = 1'b1;
            cs[RUN2]: ns[RUN3] = 1'b1;
            cs[RUN3]: ns[ctl.credit_ok ? RUN4 : RUN3] = 1'b1;
            // one waveform per fill, so the last burst goes straight to the checksum
            cs[RUN4]: ns[ctl.burst_cntr_zero ? CHECKSUM1 : RUN1] = 1'b1;
            cs[CHECKSUM1]: ns[ctl.credit_ok ? CHECKSUM2 : CHECKSUM1] = 1'b1;
            cs[CHECKSUM2]: ns[DRAIN_WAIT] = 1'b1;
            // the memory writer has taken the whole record once all credits are back
            cs[DRAIN_WAIT]: ns[ctl.credits_home ? DONE : DRAIN_WAIT] = 1'b1;
            // hold off a retrigger while the trigger is still high
            cs[DONE]: ns[(mode_enabled && trig_seen) ? DONE : IDLE] = 1'b1;
            default: ns[IDLE] = 1'b1;
        endcase
    end

    // outputs are registered from ns so they change on state entry
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            ctl.fill_type <= '0;
            ctl.fill_hdr_sel <= 1'b0;
            ctl.wfm_hdr_sel <= 1'b0;
            ctl.dat_sel <= 1'b0;
            ctl.csum_sel <= 1'b0;
            ctl.csum_update <= 1'b0;
            ctl.out_valid <= 1'b0;
            ctl.burst_cntr_init <= 1'b0;
            ctl.burst_cntr_en <= 1'b0;
            ctl.fill_cntr_en <= 1'b0;
            ctl.init_rd_addr <= 1'b0;
            ctl.fetch_burst <= 1'b0;
            ctl.capture_en <= 1'b1;
            acq_done <= 1'b0;
            sm_idle <= 1'b1;
        end else begin
            // fill type is taken on arming and held through the fill
            if (ns[WATCH_FOR_TRIG]) begin
                ctl.fill_type <= fill_type_sync;
            end
            // mux selects
            ctl.fill_hdr_sel <= ns[FILL_INIT1];
            ctl.wfm_hdr_sel <= ns[WAVEFORM_INIT2];
            ctl.dat_sel <= ns[RUN3];
            ctl.csum_sel <= ns[CHECKSUM1];
            // one strobe per write state
            ctl.out_valid <= ns[FILL_INIT2] | ns[WAVEFORM_INIT3] | ns[RUN4] | ns[CHECKSUM2];
            ctl.csum_update <= ns[RUN4];
            // read pointer and burst count both set up at waveform start
            ctl.burst_cntr_init <= ns[WAVEFORM_INIT1];
            ctl.init_rd_addr <= ns[WAVEFORM_INIT1];
            ctl.burst_cntr_en <= ns[RUN1];
            ctl.fetch_burst <= ns[RUN1];
            ctl.fill_cntr_en <= ns[CHECKSUM2];
            // buffer keeps recording only while waiting for a trigger
            ctl.capture_en <= ns[IDLE] | ns[WATCH_FOR_TRIG];
            sm_idle <= ns[IDLE];
            // single pulse on entry to DONE
            acq_done <= ns[DONE] & ~cs[DONE];
        end
    end

endmodule

// ==== design/circ_buf_reader.sv ====
module circ_buf_reader (
    input  logic                   clk,
    input  logic                   adc_acq_full_reset,
    input  acq_cfg_pkg::buf_word_t adc_data,
    acq_ctl_if.reader              ctl
);
    import acq_cfg_pkg::*;

    // sample ram, four read lanes for the burst fetch
    buf_word_t mem [BUF_DEPTH];

    buf_addr_t wr_ptr;
    buf_addr_t rd_ptr;
    // words in this fill
    buf_addr_t span;
    // oldest word of the fill in the frozen buffer
    buf_addr_t start_calc;

    // record continuously until the sequencer freezes the buffer
    always_ff @(posedge clk) begin
        if (ctl.capture_en) begin
            mem[wr_ptr] <= adc_data;
        end
    end

    // write pointer only moves on a write
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            wr_ptr <= '0;
        end else if (ctl.capture_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // up to 8 bursts of 4 words, always below BUF_DEPTH
    assign span = buf_addr_t'(ctl.burst_total * BURST_WORDS);

    // the fill ends at the last word written before the freeze
    assign start_calc = wr_ptr - span;

    // read pointer steps one burst per fetch
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            rd_ptr <= '0;
            ctl.start_addr <= '0;
        end else if (ctl.init_rd_addr) begin
            rd_ptr <= start_calc;
            // same address goes into the waveform header
            ctl.start_addr <= start_calc;
        end else if (ctl.fetch_burst) begin
            rd_ptr <= rd_ptr + buf_addr_t'(BURST_WORDS);
        end
    end

    // one-cycle read of four consecutive words
    // lowest address lands in bits 31:0, addresses wrap around the buffer
    always_ff @(posedge clk) begin
        if (ctl.fetch_burst) begin
            for (int l = 0; l < BURST_WORDS; l++) begin
                ctl.burst_data[l*BUF_WORD_W +: BUF_WORD_W] <= mem[rd_ptr + buf_addr_t'(l)];
            end
        end
    end

endmodule

// ==== design/acq_record_builder.sv ====
module acq_record_builder (
    input  logic                   clk,
    input  logic                   adc_acq_full_reset,
    input  logic                   rec_credit,
    acq_ctl_if.builder             ctl,
    output logic                   rec_valid,
    output acq_cfg_pkg::rec_word_t rec_data
);
    import acq_cfg_pkg::*;
    import acq_rec_pkg::*;

    burst_cnt_t burst_cnt;
    fill_num_t fill_num;
    csum_t csum;
    csum_t lane_sum;
    credit_cnt_t credit_cnt;

    // selected word and its holding register
    rec_word_t word_mux;
    rec_word_t word_q;

    // burst count for the current fill type
    assign ctl.burst_total = FILL_BURSTS[ctl.fill_type];

    // counts bursts still to fetch
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            burst_cnt <= '0;
        end else if (ctl.burst_cntr_init) begin
            burst_cnt <= ctl.burst_total;
        end else if (ctl.burst_cntr_en && burst_cnt != '0) begin
            burst_cnt <= burst_cnt - 1'b1;
        end
    end

    assign ctl.burst_cntr_zero = (burst_cnt == '0);

    // fill number, first fill after reset is 0
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            fill_num <= '0;
        end else if (ctl.fill_cntr_en) begin
            fill_num <= fill_num + 1'b1;
        end
    end

    // sum of the four 32-bit lanes of the current burst
    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < BURST_WORDS; l++) begin
            lane_sum = lane_sum + ctl.burst_data[l*BUF_WORD_W +: BUF_WORD_W];
        end
    end

    // wrapping checksum, restarts with each fill header
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            csum <= '0;
        end else if (ctl.fill_hdr_sel) begin
            csum <= '0;
        end else if (ctl.csum_update) begin
            csum <= csum + lane_sum;
        end
    end

    // word mux, unused bits stay zero
    always_comb begin
        word_mux = '0;
        if (ctl.fill_hdr_sel) begin
            word_mux[127:124] = TAG_FILL_HDR;
            word_mux[31:16] = fill_num;
            word_mux[15:8] = ctl.burst_total;
            word_mux[1:0] = ctl.fill_type;
        end else if (ctl.wfm_hdr_sel) begin
            word_mux[127:124] = TAG_WFM_HDR;
            word_mux[5:0] = ctl.start_addr;
        end else if (ctl.dat_sel) begin
            // data bursts go out untagged
            word_mux = ctl.burst_data;
        end else if (ctl.csum_sel) begin
            word_mux[127:124] = TAG_CSUM;
            word_mux[31:0] = csum;
        end
    end

    // the select state loads the word, the write state sends it
    always_ff @(posedge clk) begin
        if (ctl.fill_hdr_sel || ctl.wfm_hdr_sel || ctl.dat_sel || ctl.csum_sel) begin
            word_q <= word_mux;
        end
        if (ctl.out_valid) begin
            rec_data <= word_q;
        end
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= ctl.out_valid;
        end
    end

    // credit pool
    // a credit is taken on the write strobe, one cycle ahead of rec_valid,
    // so a select state right after a write already sees the reduced count
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            credit_cnt <= credit_cnt_t'(CREDIT_MAX);
        end else begin
            case ({ctl.out_valid, rec_credit})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    assign ctl.credit_ok = (credit_cnt != '0);
    assign ctl.credits_home = (credit_cnt == credit_cnt_t'(CREDIT_MAX));

endmodule

// ==== design/adc_acq_top.sv ====
module adc_acq_top (
    input  logic                   clk,
    input  logic                   adc_acq_full_reset,
    input  acq_cfg_pkg::buf_word_t adc_data,
    input  logic                   acq_enable0,
    input  logic                   acq_enable1,
    input  logic                   acq_trig,
    input  logic                   rec_credit,
    output logic                   rec_valid,
    output acq_cfg_pkg::rec_word_t rec_data,
    output logic                   acq_enabled,
    output logic                   acq_done,
    output logic                   sm_idle
);

    // strobes and status between the sequencer and the datapath
    acq_ctl_if ctl_if ();

    adc_acq_sm_cbuf u_adc_acq_sm_cbuf (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .acq_enable0        (acq_enable0),
        .acq_enable1        (acq_enable1),
        .acq_trig           (acq_trig),
        .ctl                (ctl_if.seq),
        .acq_done           (acq_done),
        .sm_idle            (sm_idle)
    );

    circ_buf_reader u_circ_buf_reader (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .adc_data           (adc_data),
        .ctl                (ctl_if.reader)
    );

    acq_record_builder u_acq_record_builder (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .rec_credit         (rec_credit),
        .ctl                (ctl_if.builder),
        .rec_valid          (rec_valid),
        .rec_data           (rec_data)
    );

    // high while a triggered record is in progress, inverted sense kept from the board
    assign acq_enabled = ~ctl_if.capture_en;

endmodule

// ==== bench/adc_acq_asserts.sv ====
module adc_acq_asserts #(
    // 1 checks the sequencer side, 0 checks the credit pool
    parameter bit SEQ_SIDE = 1'b1
) (
    input logic                     clk,
    input logic                     adc_acq_full_reset,
    input acq_rec_pkg::state_vec_t  state_vec,
    input logic                     acq_done,
    input acq_cfg_pkg::credit_cnt_t credit_cnt,
    input logic                     out_valid
);
    import acq_cfg_pkg::*;
    import acq_rec_pkg::*;

    if (SEQ_SIDE) begin : g_seq
        // exactly one state bit set at any time
        assert property (@(posedge clk) disable iff (adc_acq_full_reset) $onehot(state_vec))
            else $error("sequencer state vector is not one-hot");
        // acq_done is a single-cycle pulse
        assert property (@(posedge clk) disable iff (adc_acq_full_reset) acq_done |=> !acq_done)
            else $error("acq_done high for two cycles in a row");
    end else begin : g_credit
        // free credits below zero would wrap above the limit
        assert property (@(posedge clk) disable iff (adc_acq_full_reset)
            credit_cnt <= credit_cnt_t'(CREDIT_MAX))
            else $error("more record words outstanding than CREDIT_MAX");
        // a write strobe always has a credit to spend
        assert property (@(posedge clk) disable iff (adc_acq_full_reset)
            out_valid |-> credit_cnt != '0)
            else $error("record word sent with no credit left");
    end

endmodule

bind adc_acq_sm_cbuf adc_acq_asserts #(.SEQ_SIDE(1'b1)) u_seq_asserts (
    .clk                (clk),
    .adc_acq_full_reset (adc_acq_full_reset),
    .state_vec          (cs),
    .acq_done           (acq_done),
    .credit_cnt         ('0),
    .out_valid          (1'b0)
);

bind acq_record_builder adc_acq_asserts #(.SEQ_SIDE(1'b0)) u_credit_asserts (
    .clk                (clk),
    .adc_acq_full_reset (adc_acq_full_reset),
    .state_vec          ('0),
    .acq_done           (1'b0),
    .credit_cnt         (credit_cnt),
    .out_valid          (ctl.out_valid)
);

// ==== bench/tb_adc_acq.sv ====
module tb_adc_acq;
    import acq_cfg_pkg::*;
    import acq_rec_pkg::*;

    localparam int NUM_FILLS = 40;
    // generous bound per fill plus setup time
    localparam int CYCLE_LIMIT = NUM_FILLS * 400 + 2000;

    logic clk;
    logic adc_acq_full_reset;
    buf_word_t adc_data;
    logic acq_enable0;
    logic acq_enable1;
    logic acq_trig;
    logic rec_credit;
    logic rec_valid;
    rec_word_t rec_data;
    logic acq_enabled;
    logic acq_done;
    logic sm_idle;

    int seed;
    int errors;
    int cyc;

    // mirror of the sample buffer
    buf_word_t model_mem [BUF_DEPTH];
    buf_addr_t model_wp;

    // record checker state
    fill_type_t fill_ft;
    int expect_fills;
    int fill_no;
    int done_cnt;
    int word_idx;
    int num_bursts;
    buf_addr_t wfm_start;
    csum_t model_csum;

    // credit sink, cycle numbers at which each credit goes back
    int outstanding;
    int credit_due [$];

    adc_acq_top u_adc_acq_top (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .adc_data           (adc_data),
        .acq_enable0        (acq_enable0),
        .acq_enable1        (acq_enable1),
        .acq_trig           (acq_trig),
        .rec_credit         (rec_credit),
        .rec_valid          (rec_valid),
        .rec_data           (rec_data),
        .acq_enabled        (acq_enabled),
        .acq_done           (acq_done),
        .sm_idle            (sm_idle)
    );

    always #10 clk = ~clk;

    task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // bursts per fill from the enables
    function automatic int bursts_for(input fill_type_t ft);
        case (ft)
            2'd1: return 2;
            2'd2: return 4;
            2'd3: return 8;
            default: return 0;
        endcase
    endfunction

    // tag on top, fields in the low word, rest zero
    function automatic rec_word_t tagged_word(input tag_t tag, input logic [31:0] low);
        rec_word_t w;
        w = '0;
        w[127:124] = tag;
        w[31:0] = low;
        return w;
    endfunction

    always @(posedge clk) begin
        rec_word_t exp_word;
        buf_addr_t base;
        int due_idx;
        cyc++;
        // buffer mirror, pointer held at zero in reset
        if (acq_enabled === 1'b0) begin
            model_mem[model_wp] = adc_data;
            if (!adc_acq_full_reset) model_wp = model_wp + 1'b1;
        end
        if (adc_acq_full_reset) model_wp = '0;
        adc_data <= $random(seed);
        if (rec_valid === 1'b1) begin
            outstanding++;
            if (outstanding > CREDIT_MAX) begin
                errors++;
                $display("error: %0d record words outstanding at %0t, above the credit limit",
                         outstanding, $time);
            end
            credit_due.push_back(cyc + ($random(seed) & 7));
            if (word_idx == 0) begin
                if (fill_no >= expect_fills) begin
                    errors++;
                    $display("error: record started at %0t with no accepted trigger", $time);
                end
                num_bursts = bursts_for(fill_ft);
                // fill ends at the last word written before the freeze
                wfm_start = model_wp - buf_addr_t'(num_bursts * BURST_WORDS);
                model_csum = '0;
                exp_word = tagged_word(TAG_FILL_HDR, {fill_num_t'(fill_no),
                    burst_cnt_t'(num_bursts), 6'd0, fill_ft});
            end else if (word_idx == 1) begin
                exp_word = tagged_word(TAG_WFM_HDR, {26'd0, wfm_start});
            end else if (word_idx <= num_bursts + 1) begin
                base = wfm_start + buf_addr_t'((word_idx - 2) * BURST_WORDS);
                for (int l = 0; l < BURST_WORDS; l++) begin
                    exp_word[l*32 +: 32] = model_mem[base + buf_addr_t'(l)];
                    model_csum = model_csum + model_mem[base + buf_addr_t'(l)];
                end
            end else begin
                exp_word = tagged_word(TAG_CSUM, model_csum);
            end
            check_equal(rec_data, exp_word, $sformatf("fill %0d word %0d", fill_no, word_idx));
            if (word_idx == num_bursts + 2) begin
                word_idx = 0;
                fill_no++;
            end else begin
                word_idx++;
            end
        end
        if (acq_done === 1'b1) begin
            done_cnt++;
            check_equal(word_idx, 0, "record incomplete at acq_done");
            check_equal(outstanding, 0, "credits outstanding at acq_done");
            check_equal(done_cnt, fill_no, "acq_done count against records");
            check_equal(acq_enabled, 1'b1, "acq_enabled at acq_done");
        end
        // one credit pulse per cycle, first due entry wins
        due_idx = -1;
        for (int i = 0; i < credit_due.size(); i++) begin
            if (due_idx < 0 && credit_due[i] <= cyc) due_idx = i;
        end
        if (due_idx >= 0) begin
            credit_due.delete(due_idx);
            outstanding--;
            rec_credit <= 1'b1;
        end else begin
            rec_credit <= 1'b0;
        end
        if (cyc >= CYCLE_LIMIT) begin
            errors++;
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d", errors);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        fill_type_t ft;
        int gap;
        int hold;
        clk = 1'b0;
        adc_acq_full_reset = 1'b1;
        adc_data = '0;
        acq_enable0 = 1'b0;
        acq_enable1 = 1'b0;
        acq_trig = 1'b0;
        rec_credit = 1'b0;
        seed = 93340;
        errors = 0;
        cyc = 0;
        model_wp = '0;
        fill_ft = '0;
        expect_fills = 0;
        fill_no = 0;
        done_cnt = 0;
        word_idx = 0;
        num_bursts = 0;
        wfm_start = '0;
        model_csum = '0;
        outstanding = 0;
        repeat (3) @(posedge clk);
        adc_acq_full_reset <= 1'b0;
        @(negedge clk);
        check_equal(sm_idle, 1'b1, "sm_idle after reset");
        check_equal(acq_enabled, 1'b0, "acq_enabled after reset");
        check_equal(rec_valid, 1'b0, "rec_valid after reset");
        check_equal(acq_done, 1'b0, "acq_done after reset");
        // whole buffer written once before the first trigger
        repeat (BUF_DEPTH + 8) @(posedge clk);
        for (int f = 0; f < NUM_FILLS; f++) begin
            // draws on the falling edge, away from the per-cycle data draws
            @(negedge clk);
            ft = fill_type_t'($random(seed));
            gap = $random(seed) & 15;
            hold = $random(seed) & 7;
            @(posedge clk);
            acq_enable0 <= ft[0];
            acq_enable1 <= ft[1];
            fill_ft <= ft;
            // enables through the synchronizer before the trigger
            repeat (8 + gap) @(posedge clk);
            acq_trig <= 1'b1;
            if (ft != 2'd0) begin
                expect_fills <= expect_fills + 1;
                while (acq_done !== 1'b1) @(posedge clk);
                // trigger stays high a while, no second record allowed
                repeat (hold) @(posedge clk);
            end else begin
                repeat (6) @(posedge clk);
                repeat (12) begin
                    @(posedge clk);
                    check_equal(sm_idle, 1'b1, "sm_idle with acquisition off");
                    check_equal(acq_enabled, 1'b0, "acq_enabled with acquisition off");
                end
            end
            acq_trig <= 1'b0;
            repeat (8) @(posedge clk);
        end
        repeat (20) @(posedge clk);
        @(negedge clk);
        check_equal(fill_no, expect_fills, "records against accepted triggers");
        check_equal(done_cnt, expect_fills, "acq_done pulses against accepted triggers");
        check_equal(credit_due.size(), 0, "credits still pending at end");
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== project.f ====
design/acq_cfg_pkg.sv
design/acq_rec_pkg.sv
design/acq_ctl_if.sv
design/adc_acq_sm_cbuf.sv
design/circ_buf_reader.sv
design/acq_record_builder.sv
design/adc_acq_top.sv
bench/adc_acq_asserts.sv
bench/tb_adc_acq.sv

// ==== Bender.yml ====
package:
  name: adc_acq

sources:
  - files:
      - design/acq_cfg_pkg.sv
      - design/acq_rec_pkg.sv
      - design/acq_ctl_if.sv
      - design/adc_acq_sm_cbuf.sv
      - design/circ_buf_reader.sv
      - design/acq_record_builder.sv
      - design/adc_acq_top.sv
  - target: test
    files:
      - bench/adc_acq_asserts.sv
      - bench/tb_adc_acq.sv
